/* UfiRamSubsystem.f */
+incdir+include
hw/UfiPkg.sv
hw/SyncFifo.sv
hw/UfiCommandDecode.sv
hw/RamReadWriteArbiter.sv
hw/RamBlockArray.sv
hw/UfiReadReturn.sv
hw/UfiRamSubsystem.sv
tb/UfiRamSubsystem_properties.sv
tb/UfiRamSubsystemTb.sv

/* Bender.yml */
package:
  name: ufi_ram_subsystem

export_include_dirs:
  - include

sources:
  - files:
      - hw/UfiPkg.sv
      - hw/SyncFifo.sv
      - hw/UfiCommandDecode.sv
      - hw/RamReadWriteArbiter.sv
      - hw/RamBlockArray.sv
      - hw/UfiReadReturn.sv
      - hw/UfiRamSubsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/UfiRamSubsystem_properties.sv
      - tb/UfiRamSubsystemTb.sv

/* tb/UfiRamSubsystemTb.sv */
//------------------------------------------------------------
// Testbench for the UFI RAM slave: clock, reset, stimulus
// Memory reference model, response checks, watchdog
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module UfiRamSubsystemTb import UfiPkg::*; ();

	// Test lengths in commands
	localparam int wrRdCount    = 32;
	localparam int orderPool    = 8;
	localparam int orderOps     = 48;
	localparam int invalidCount = 8;
	localparam int burstOps     = 64;
	localparam int stimCycles   = 2 * wrRdCount + orderPool + orderOps + invalidCount + burstOps + 8;

	logic                         iCLK = 1'b0;
	logic                         rst;
	logic                         cmdStrobe;
	ufiCmdT                       ufiCmd;
	logic                         rdy;
	logic                         rspStrobe;
	ufiRspT                       rsp;
	logic [`UFI_COUNT_WIDTH-1:0]  rspCount;
	logic [`UFI_COUNT_WIDTH-1:0]  errCount;

	// Reference model state
	logic [`UFI_DQ_WIDTH-1:0] refMem [int];
	ufiRspT                   expQ [$];
	ufiRspT                   expRsp;
	logic [28:0]              written [$];
	logic [28:0]              pool [$];
	integer                   seed;
	int                       readsSent = 0;
	int                       expErr = 0;
	// Bookkeeping
	int                       errorCount = 0;
	int                       checkCount = 0;
	int                       testCount = 0;
	int                       testStart = 0;
	int                       rdyLowCycles = 0;
	logic                     inBurst = 1'b0;

	UfiRamSubsystem dut (
		.iCLK      (iCLK),
		.rst       (rst),
		.cmdStrobe (cmdStrobe),
		.ufiCmd    (ufiCmd),
		.rdy       (rdy),
		.rspStrobe (rspStrobe),
		.rsp       (rsp),
		.rspCount  (rspCount),
		.errCount  (errCount)
	);

	initial
	begin
		forever #5 iCLK = ~iCLK;
	end

	//----------------------------------------------------------
	// Helpers
	//----------------------------------------------------------
	// Model index, low word bits inside each block
	function automatic int memKey(input logic [3:0] blk, input logic [24:0] wordAdrs);
		return {blk[1:0], wordAdrs[`UFI_RAM_ADRS_WIDTH-1:0]};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errorCount++;
			$display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Drive one command once rdy allows, model updated at issue
	task automatic sendCmd(input logic enable, input logic isRead, input logic [3:0] blk,
		input logic [24:0] wordAdrs, input logic [15:0] data);
		logic [31:0] adrs;
		adrs = {enable, isRead, 1'b0, blk, wordAdrs};
		while (!rdy)
		begin
			cmdStrobe <= 1'b0;
			@(posedge iCLK);
		end
		cmdStrobe <= 1'b1;
		ufiCmd    <= '{adrs: adrs, wd: data};
		if (enable && blk >= `UFI_BLOCK_COUNT)
			expErr++;
		else if (enable && isRead)
		begin
			readsSent++;
			expQ.push_back('{adrs: adrs, rd: refMem[memKey(blk, wordAdrs)]});
		end
		else if (enable)
			refMem[memKey(blk, wordAdrs)] = data;
		@(posedge iCLK);
	endtask

	// Idle until every expected response is back
	task automatic drain();
		cmdStrobe <= 1'b0;
		while (expQ.size() != 0)
			@(posedge iCLK);
		@(posedge iCLK);
	endtask

	task automatic reportTest(input string name, input string note);
		testCount++;
		$display("test %0d %s finished, %0d errors %s", testCount, name,
			errorCount - testStart, note);
		testStart = errorCount;
	endtask

	//----------------------------------------------------------
	// Response monitor, sampled mid cycle
	//----------------------------------------------------------
	always @(negedge iCLK)
	begin
		if (rst === 1'b0 && rspStrobe === 1'b1)
		begin
			assert (expQ.size() != 0)
			else
			begin
				errorCount++;
				$display("response arrived at %0t with no read outstanding", $time);
			end
			if (expQ.size() != 0)
			begin
				expRsp = expQ.pop_front();
				checkValue("rsp.adrs", rsp.adrs, expRsp.adrs);
				checkValue("rsp.rd", 32'(rsp.rd), 32'(expRsp.rd));
			end
		end
		if (inBurst && !rdy)
			rdyLowCycles++;
	end

	// Watchdog
	initial
	begin
		#(stimCycles * 20 * 10);
		$display("watchdog expired, %0d responses still outstanding", expQ.size());
		$display("** FAIL **");
		$finish;
	end

	//----------------------------------------------------------
	// Tests
	//----------------------------------------------------------
	initial
	begin
		logic [3:0]  blk;
		logic [24:0] wordAdrs;
		logic [28:0] pair;
		int          k;
		seed      = 32'hfa28_0bd8;
		rst       = 1'b1;
		cmdStrobe = 1'b0;
		ufiCmd    = '0;

		// Reset state
		@(posedge iCLK);
		@(negedge iCLK);
		checkValue("rdy", 32'(rdy), 0);
		checkValue("rspStrobe", 32'(rspStrobe), 0);
		@(posedge iCLK);
		rst <= 1'b0;
		@(posedge iCLK);
		@(negedge iCLK);
		checkValue("rdy", 32'(rdy), 1);
		checkValue("rspCount", 32'(rspCount), 0);
		checkValue("errCount", 32'(errCount), 0);
		reportTest("reset state", "");
		@(posedge iCLK);

		// Writes across all blocks, then read back
		repeat (wrRdCount)
		begin
			blk      = $unsigned($random(seed)) % `UFI_BLOCK_COUNT;
			wordAdrs = $random(seed);
			sendCmd(1'b1, 1'b0, blk, wordAdrs, $random(seed));
			written.push_back({blk, wordAdrs});
		end
		foreach (written[i])
			sendCmd(1'b1, 1'b1, written[i][28:25], written[i][24:0], '0);
		drain();
		reportTest("write then read", "");

		// Interleaved traffic on a small address pool
		for (k = 0; k < orderPool; k++)
		begin
			wordAdrs = $random(seed);
			sendCmd(1'b1, 1'b0, 4'(k % `UFI_BLOCK_COUNT), wordAdrs, $random(seed));
			pool.push_back({4'(k % `UFI_BLOCK_COUNT), wordAdrs});
		end
		repeat (orderOps)
		begin
			pair = pool[$unsigned($random(seed)) % orderPool];
			if ($random(seed) & 1)
				sendCmd(1'b1, 1'b1, pair[28:25], pair[24:0], '0);
			else
				sendCmd(1'b1, 1'b0, pair[28:25], pair[24:0], $random(seed));
		end
		drain();
		reportTest("program order", "");

		// Disabled commands, then out-of-range block IDs
		repeat (invalidCount / 2)
		begin
			pair = written[$unsigned($random(seed)) % written.size()];
			sendCmd(1'b0, $random(seed), pair[28:25], pair[24:0], $random(seed));
		end
		repeat (invalidCount / 2)
		begin
			blk = 4 + ($unsigned($random(seed)) % 12);
			sendCmd(1'b1, $random(seed), blk, $random(seed), $random(seed));
		end
		// Fence read, drops are counted before it returns
		sendCmd(1'b1, 1'b1, written[0][28:25], written[0][24:0], '0);
		drain();
		checkValue("errCount", 32'(errCount), expErr);
		checkValue("rspCount", 32'(rspCount), readsSent);
		reportTest("invalid commands", "");

		// Back-to-back burst, rdy gates every strobe
		inBurst = 1'b1;
		repeat (burstOps)
		begin
			if ($random(seed) & 1)
			begin
				pair = written[$unsigned($random(seed)) % written.size()];
				sendCmd(1'b1, 1'b1, pair[28:25], pair[24:0], '0);
			end
			else
			begin
				blk      = $unsigned($random(seed)) % `UFI_BLOCK_COUNT;
				wordAdrs = $random(seed);
				sendCmd(1'b1, 1'b0, blk, wordAdrs, $random(seed));
				written.push_back({blk, wordAdrs});
			end
		end
		inBurst = 1'b0;
		drain();
		checkValue("rspCount", 32'(rspCount), readsSent);
		// One issue per cycle keeps pace with one command per cycle
		reportTest("back-pressure", $sformatf("(rdy low for %0d cycles)", rdyLowCycles));

		errorCount += dut.props.violations;
		$display("tests %0d, checks %0d, errors %0d, reads %0d", testCount, checkCount,
			errorCount, readsSent);
		if (errorCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/UfiRamSubsystem_properties.sv */
//------------------------------------------------------------
// Concurrent assertions on the UFI RAM slave top level
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module UfiRamSubsystem_properties (
	input wire                         iCLK,
	input wire                         rst,
	input wire                         rdy,
	input wire                         rspStrobe,
	input wire [`UFI_COUNT_WIDTH-1:0]  rspCount
);

	// Failed property count
	int violations = 0;

	//----------------------------------------------------------
	// Reset
	//----------------------------------------------------------
	// Outputs quiet on the cycle after a reset edge
	assert property (@(posedge iCLK) rst |=> (!rspStrobe && !rdy))
	else
	begin
		violations++;
		$error("rdy or rspStrobe high during reset");
	end

	// Ready always resolved once out of reset
	assert property (@(posedge iCLK) !rst |-> !$isunknown(rdy))
	else
	begin
		violations++;
		$error("rdy unknown after reset");
	end

	//----------------------------------------------------------
	// Counters
	//----------------------------------------------------------
	// Saturating response counter, only moves up
	assert property (@(posedge iCLK) disable iff (rst)
		!rst |=> (rspCount >= $past(rspCount)))
	else
	begin
		violations++;
		$error("rspCount decreased");
	end

endmodule

bind UfiRamSubsystem UfiRamSubsystem_properties props (.*);

`default_nettype wire

/* hw/UfiRamSubsystem.sv */
//------------------------------------------------------------
// UFI RAM slave top, decode, arbiter, RAM and result stages
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module UfiRamSubsystem import UfiPkg::*; (
	input  wire                          iCLK,
	input  wire                          rst,
	// Bus slave command
	input  wire                          cmdStrobe,
	input  ufiCmdT                       ufiCmd,
	output logic                         rdy,
	// Bus slave response
	output logic                         rspStrobe,
	output ufiRspT                       rsp,
	// Status
	output logic [`UFI_COUNT_WIDTH-1:0]  rspCount,
	output logic [`UFI_COUNT_WIDTH-1:0]  errCount
);

	// Decode to arbiter
	logic      writeStrobe;
	ufiWriteT  writeCmd;
	logic      readStrobe;
	ufiReadT   readCmd;
	logic      dropStrobe;
	// Arbiter to RAM
	logic      ramStrobe;
	ramReqT    ramReq;
	// RAM to result
	logic                        rdValid;
	logic [`UFI_DQ_WIDTH-1:0]    ramRd;
	logic [`UFI_ADRS_WIDTH-1:0]  rdAdrs;

	UfiCommandDecode Decode (
		.iCLK        (iCLK),
		.rst         (rst),
		.cmdStrobe   (cmdStrobe),
		.ufiCmd      (ufiCmd),
		.writeStrobe (writeStrobe),
		.writeCmd    (writeCmd),
		.readStrobe  (readStrobe),
		.readCmd     (readCmd),
		.dropStrobe  (dropStrobe)
	);

	RamReadWriteArbiter Arbiter (
		.iCLK        (iCLK),
		.rst         (rst),
		.writeStrobe (writeStrobe),
		.writeCmd    (writeCmd),
		.readStrobe  (readStrobe),
		.readCmd     (readCmd),
		.ramStrobe   (ramStrobe),
		.ramReq      (ramReq),
		.rdy         (rdy)
	);

	RamBlockArray Ram (
		.iCLK      (iCLK),
		.rst       (rst),
		.ramStrobe (ramStrobe),
		.ramReq    (ramReq),
		.rdValid   (rdValid),
		.ramRd     (ramRd),
		.rdAdrs    (rdAdrs)
	);

	UfiReadReturn Result (
		.iCLK       (iCLK),
		.rst        (rst),
		.rdValid    (rdValid),
		.ramRd      (ramRd),
		.rdAdrs     (rdAdrs),
		.dropStrobe (dropStrobe),
		.rsp        (rsp),
		.rspStrobe  (rspStrobe),
		.rspCount   (rspCount),
		.errCount   (errCount)
	);

endmodule

`default_nettype wire

/* hw/UfiReadReturn.sv */
//------------------------------------------------------------
// Read response register, response and drop counters
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module UfiReadReturn import UfiPkg::*; (
	input  wire                           iCLK,
	input  wire                           rst,
	// From the RAM
	input  wire                           rdValid,
	input  wire [`UFI_DQ_WIDTH-1:0]       ramRd,
	input  wire [`UFI_ADRS_WIDTH-1:0]     rdAdrs,
	// From decode
	input  wire                           dropStrobe,
	// Bus slave response
	output ufiRspT                        rsp,
	output logic                          rspStrobe,
	output logic [`UFI_COUNT_WIDTH-1:0]   rspCount,
	output logic [`UFI_COUNT_WIDTH-1:0]   errCount
);

	// Response payload, bit 31 flags valid data
	always_ff @(posedge iCLK)
	begin
		if (rdValid)
		begin
			rsp.adrs <= rdAdrs;
			rsp.adrs[`UFI_ENABLE_BIT] <= 1'b1;
			rsp.rd <= ramRd;
		end
	end

	// Strobe and saturating counters
	always_ff @(posedge iCLK)
	begin
		if (rst)
		begin
			rspStrobe <= 1'b0;
			rspCount  <= '0;
			errCount  <= '0;
		end
		else
		begin
			rspStrobe <= rdValid;
			if (rdValid && (rspCount != '1))
				rspCount <= rspCount + 1'b1;
			if (dropStrobe && (errCount != '1))
				errCount <= errCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/RamBlockArray.sv */
//------------------------------------------------------------
// Block-banked RAM, registered read with address echo
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module RamBlockArray import UfiPkg::*; (
	input  wire                              iCLK,
	input  wire                              rst,
	// Request from the arbiter
	input  wire                              ramStrobe,
	input  ramReqT                           ramReq,
	// Read result, one cycle after the request
	output logic                             rdValid,
	output logic [`UFI_DQ_WIDTH-1:0]         ramRd,
	output logic [`UFI_ADRS_WIDTH-1:0]       rdAdrs
);

	localparam int ramWords = 2 ** `UFI_RAM_ADRS_WIDTH;

	logic [`UFI_RAM_ADRS_WIDTH-1:0] ramIndex;
	logic [`UFI_DQ_WIDTH-1:0]       bankRd [`UFI_BLOCK_COUNT];
	logic [blockWidth-1:0]          rdBlock;

	// Only the low word bits are implemented
	assign ramIndex = ramReq.ramAdrs[`UFI_RAM_ADRS_WIDTH-1:0];

	//----------------------------------------------------------
	// One bank per block ID
	//----------------------------------------------------------
	for (genvar b = 0; b < `UFI_BLOCK_COUNT; b++)
	begin : Bank
		logic [`UFI_DQ_WIDTH-1:0] bankMem [ramWords];
		logic                     bankSel;

		assign bankSel = ramStrobe && (ramReq.block == blockWidth'(b));

		always_ff @(posedge iCLK)
		begin
			if (bankSel && ramReq.we)
				bankMem[ramIndex] <= ramReq.wd;
			// Registered read port
			if (bankSel && !ramReq.we)
				bankRd[b] <= bankMem[ramIndex];
		end
	end

	// Read valid
	always_ff @(posedge iCLK)
	begin
		if (rst)
			rdValid <= 1'b0;
		else
			rdValid <= ramStrobe && !ramReq.we;
	end

	// Bank select and address echo follow the read
	always_ff @(posedge iCLK)
	begin
		if (ramStrobe && !ramReq.we)
		begin
			rdBlock <= ramReq.block;
			rdAdrs  <= ramReq.adrsEcho;
		end
	end

	assign ramRd = bankRd[rdBlock];

endmodule

`default_nettype wire

/* hw/RamReadWriteArbiter.sv */
//------------------------------------------------------------
// Write and read queues with in-order issue to the block RAM
// Registered ready from both queue levels
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module RamReadWriteArbiter import UfiPkg::*; (
	input  wire       iCLK,
	input  wire       rst,
	// From decode
	input  wire       writeStrobe,
	input  ufiWriteT  writeCmd,
	input  wire       readStrobe,
	input  ufiReadT   readCmd,
	// RAM request port
	output logic      ramStrobe,
	output ramReqT    ramReq,
	// Bus slave ready
	output logic      rdy
);

	localparam int fifoCountWidth = $clog2(`UFI_FIFO_DEPTH + 1);
	// Headroom for the decode register and the ready register
	localparam int readyLimit     = `UFI_FIFO_DEPTH - 3;

	ufiWriteT                  writeHead;
	ufiReadT                   readHead;
	logic                      writeEmpty;
	logic                      readEmpty;
	logic [fifoCountWidth-1:0] writeLevel;
	logic [fifoCountWidth-1:0] readLevel;
	logic [markWidth-1:0]      issuedWrites;
	logic                      issueRead;
	logic                      issueWrite;

	//----------------------------------------------------------
	// Queues
	//----------------------------------------------------------
	SyncFifo #(
		.payloadT (ufiWriteT),
		.depth    (`UFI_FIFO_DEPTH)
	) WriteFifo (
		.iCLK  (iCLK),
		.rst   (rst),
		.we    (writeStrobe),
		.wd    (writeCmd),
		.re    (issueWrite),
		.rd    (writeHead),
		.empty (writeEmpty),
		.count (writeLevel)
	);

	SyncFifo #(
		.payloadT (ufiReadT),
		.depth    (`UFI_FIFO_DEPTH)
	) ReadFifo (
		.iCLK  (iCLK),
		.rst   (rst),
		.we    (readStrobe),
		.wd    (readCmd),
		.re    (issueRead),
		.rd    (readHead),
		.empty (readEmpty),
		.count (readLevel)
	);

	//----------------------------------------------------------
	// Issue
	//----------------------------------------------------------
	// Read goes once every older write has been issued
	assign issueRead  = !readEmpty && (issuedWrites == readHead.writeMark);
	assign issueWrite = !issueRead && !writeEmpty;
	assign ramStrobe  = issueRead || issueWrite;

	always_comb
	begin
		ramReq = '0;
		// Echo carries direction, block and word address
		if (issueRead)
		begin
			ramReq.we      = 1'b0;
			ramReq.block   = readHead.block;
			ramReq.ramAdrs = readHead.ramAdrs;
			ramReq.adrsEcho[`UFI_READ_BIT] = 1'b1;
			ramReq.adrsEcho[`UFI_BLOCK_MSB:`UFI_BLOCK_LSB] = blockFieldWidth'(readHead.block);
			ramReq.adrsEcho[wordAdrsWidth-1:0] = readHead.ramAdrs;
		end
		else
		begin
			ramReq.we      = 1'b1;
			ramReq.block   = writeHead.block;
			ramReq.ramAdrs = writeHead.ramAdrs;
			ramReq.wd      = writeHead.wd;
			ramReq.adrsEcho[`UFI_BLOCK_MSB:`UFI_BLOCK_LSB] = blockFieldWidth'(writeHead.block);
			ramReq.adrsEcho[wordAdrsWidth-1:0] = writeHead.ramAdrs;
		end
	end

	// Issued writes, compared against the read stamps
	always_ff @(posedge iCLK)
	begin
		if (rst)
			issuedWrites <= '0;
		else if (issueWrite)
			issuedWrites <= issuedWrites + 1'b1;
	end

	//----------------------------------------------------------
	// Ready
	//----------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (rst)
			rdy <= 1'b0;
		else
			rdy <= (writeLevel <= readyLimit) && (readLevel <= readyLimit);
	end

endmodule

`default_nettype wire

/* hw/UfiCommandDecode.sv */
//------------------------------------------------------------
// Command decode stage, field split and block ID check
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

module UfiCommandDecode import UfiPkg::*; (
	input  wire       iCLK,
	input  wire       rst,
	// Bus slave command
	input  wire       cmdStrobe,
	input  ufiCmdT    ufiCmd,
	// To the arbiter
	output logic      writeStrobe,
	output ufiWriteT  writeCmd,
	output logic      readStrobe,
	output ufiReadT   readCmd,
	// Rejected command
	output logic      dropStrobe
);

	logic                       cmdEnable;
	logic                       cmdRead;
	logic [blockFieldWidth-1:0] cmdBlock;
	logic                       blockOk;
	logic [markWidth-1:0]       writeCount;

	// Strobe with the enable bit low is not a command
	assign cmdEnable = cmdStrobe && ufiCmd.adrs[`UFI_ENABLE_BIT];
	assign cmdRead   = ufiCmd.adrs[`UFI_READ_BIT];
	assign cmdBlock  = ufiCmd.adrs[`UFI_BLOCK_MSB:`UFI_BLOCK_LSB];
	assign blockOk   = (cmdBlock < `UFI_BLOCK_COUNT);

	// Strobes and write counter
	always_ff @(posedge iCLK)
	begin
		if (rst)
		begin
			writeStrobe <= 1'b0;
			readStrobe  <= 1'b0;
			dropStrobe  <= 1'b0;
			writeCount  <= '0;
		end
		else
		begin
			writeStrobe <= cmdEnable && blockOk && !cmdRead;
			readStrobe  <= cmdEnable && blockOk && cmdRead;
			dropStrobe  <= cmdEnable && !blockOk;
			// Writes accepted so far, read stamps use this
			if (cmdEnable && blockOk && !cmdRead)
				writeCount <= writeCount + 1'b1;
		end
	end

	// Payload registers, loaded on any enabled command
	always_ff @(posedge iCLK)
	begin
		if (cmdEnable)
		begin
			writeCmd.block     <= cmdBlock[blockWidth-1:0];
			writeCmd.ramAdrs   <= ufiCmd.adrs[wordAdrsWidth-1:0];
			writeCmd.wd        <= ufiCmd.wd;
			readCmd.block      <= cmdBlock[blockWidth-1:0];
			readCmd.ramAdrs    <= ufiCmd.adrs[wordAdrsWidth-1:0];
			readCmd.writeMark  <= writeCount;
		end
	end

endmodule

`default_nettype wire

/* hw/SyncFifo.sv */
//------------------------------------------------------------
// Synchronous FIFO, generic payload type, occupancy count
//------------------------------------------------------------
`default_nettype none

module SyncFifo #(
	parameter type payloadT = logic,
	parameter int  depth    = 16
)(
	input  wire                            iCLK,
	input  wire                            rst,
	// Push side
	input  wire                            we,
	input  payloadT                        wd,
	// Pop side, head visible without a read
	input  wire                            re,
	output payloadT                        rd,
	output logic                           empty,
	output logic [$clog2(depth+1)-1:0]     count
);

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

	// Storage, no reset
	payloadT              mem [depth];
	logic [ptrWidth-1:0]  wrPtr;
	logic [ptrWidth-1:0]  rdPtr;
	logic                 doPush;
	logic                 doPop;

	// Overflow and underflow requests are ignored
	assign doPush = we && (count < depth);
	assign doPop  = re && !empty;

	assign empty = (count == '0);
	assign rd    = mem[rdPtr];

	//----------------------------------------------------------
	// Data
	//----------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= wd;
		end
	end

	//----------------------------------------------------------
	// Pointers and count
	//----------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Wrap explicitly, depth need not be a power of two
			if (doPush)
			begin
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			// Push and pop together leave the level alone
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/UfiPkg.sv */
//------------------------------------------------------------
// Command, RAM request and response structs of the UFI slave
//------------------------------------------------------------
`default_nettype none

`include "ufi_defs.svh"

package UfiPkg;

	// Field widths derived from the command layout
	localparam int blockWidth      = $clog2(`UFI_BLOCK_COUNT);
	localparam int blockFieldWidth = `UFI_BLOCK_MSB - `UFI_BLOCK_LSB + 1;
	localparam int wordAdrsWidth   = `UFI_BLOCK_LSB;
	// Snapshot of accepted writes, wraps
	localparam int markWidth       = 8;

	// Raw bus command as driven by the master
	typedef struct packed {
		logic [`UFI_ADRS_WIDTH-1:0] adrs;
		logic [`UFI_DQ_WIDTH-1:0]   wd;
	} ufiCmdT;

	// Queued write
	typedef struct packed {
		logic [blockWidth-1:0]      block;
		logic [wordAdrsWidth-1:0]   ramAdrs;
		logic [`UFI_DQ_WIDTH-1:0]   wd;
	} ufiWriteT;

	// Queued read, ordered against writes by writeMark
	typedef struct packed {
		logic [blockWidth-1:0]      block;
		logic [wordAdrsWidth-1:0]   ramAdrs;
		logic [markWidth-1:0]       writeMark;
	} ufiReadT;

	// One access issued to the block RAM
	typedef struct packed {
		logic                       we;
		logic [blockWidth-1:0]      block;
		logic [wordAdrsWidth-1:0]   ramAdrs;
		logic [`UFI_DQ_WIDTH-1:0]   wd;
		logic [`UFI_ADRS_WIDTH-1:0] adrsEcho;
	} ramReqT;

	// Read response returned to the master
	typedef struct packed {
		logic [`UFI_ADRS_WIDTH-1:0] adrs;
		logic [`UFI_DQ_WIDTH-1:0]   rd;
	} ufiRspT;

endpackage

`default_nettype wire

/* include/ufi_defs.svh */
//------------------------------------------------------------
// Bus widths, FIFO depth and block count of the UFI RAM slave
// Bit positions inside the command address word
//------------------------------------------------------------
`ifndef UFI_DEFS_SVH
`define UFI_DEFS_SVH

// Data and command word widths
`define UFI_DQ_WIDTH        16
`define UFI_ADRS_WIDTH      32

// Implemented RAM words per block, upper word bits ignored
`define UFI_RAM_ADRS_WIDTH  6
`define UFI_BLOCK_COUNT     4

// Queue depth, keep at 128 or less for the 8-bit write mark
`define UFI_FIFO_DEPTH      16

// Response and error counters
`define UFI_COUNT_WIDTH     16

// Command word layout
`define UFI_ENABLE_BIT      31
`define UFI_READ_BIT        30
`define UFI_BLOCK_MSB       28
`define UFI_BLOCK_LSB       25

`endif
